// ==== common/instrDec_config.svh ====
`ifndef INSTR_DEC_CONFIG_SVH
`define INSTR_DEC_CONFIG_SVH

// --------------------------------------------------
// Word widths
// --------------------------------------------------

`define OPCODE_WIDTH  7      // Instruction opcode
`define ALU_OP_WIDTH  6      // Registered ALU operation code

// --------------------------------------------------
// Instruction family enables
// --------------------------------------------------

// A family set to 0 decodes like NOP, with no strobes and ALU code 0

`define EN_MEM        1'b1   // LOD, P_LOD, LDI, ILI, SET, SET_P, STI, ISI
`define EN_STACK      1'b1   // PSH, POP
`define EN_IO         1'b1   // INN, P_INN, OUT
`define EN_INT_ARITH  1'b1   // ADD MLT DIV MOD SGN, NEG ABS PST
`define EN_LOGIC      1'b1   // AND ORR XOR INV, LAN LOR LIN
`define EN_COMPARE    1'b1   // LES GRE EQU
`define EN_SHIFT      1'b1   // SHL SHR SRS

`endif

// ==== common/isaPkg.sv ====
`default_nettype none

`include "instrDec_config.svh"

package isaPkg;

    // --------------------------------------------------
    // Opcodes kept in the integer-only decoder
    // --------------------------------------------------

    // Gaps in the numbering are jumps, NOP and float forms, all decoded as NOP
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        OP_LOD     = 0,  OP_P_LOD   = 1,     // Load acc from memory
        OP_LDI     = 2,  OP_ILI     = 3,     // Indirect load, plain and bit-reversed
        OP_SET     = 4,  OP_SET_P   = 5,     // Store acc, SET_P pops afterwards
        OP_STI     = 6,  OP_ISI     = 7,     // Indirect store, plain and bit-reversed
        OP_PSH     = 8,  OP_POP     = 9,     // Data stack
        OP_INN     = 10, OP_P_INN   = 12,    // Input port
        OP_OUT     = 14,                     // Output port
        OP_ADD     = 19, OP_S_ADD   = 20,
        OP_MLT     = 23, OP_S_MLT   = 24,
        OP_DIV     = 27, OP_S_DIV   = 28,
        OP_MOD     = 31, OP_S_MOD   = 32,
        OP_SGN     = 33, OP_S_SGN   = 34,    // Copy sign of one operand onto the other
        OP_NEG     = 37, OP_NEG_M   = 38,
        OP_P_NEG_M = 39,
        OP_ABS     = 43, OP_ABS_M   = 44,
        OP_P_ABS_M = 45,
        OP_PST     = 49, OP_PST_M   = 50,    // Clamp negatives to zero
        OP_P_PST_M = 51,
        OP_AND     = 64, OP_S_AND   = 65,
        OP_ORR     = 66, OP_S_ORR   = 67,
        OP_XOR     = 68, OP_S_XOR   = 69,
        OP_INV     = 70, OP_INV_M   = 71,    // Bitwise invert
        OP_P_INV_M = 72,
        OP_LAN     = 73, OP_S_LAN   = 74,    // Logical and
        OP_LOR     = 75, OP_S_LOR   = 76,    // Logical or
        OP_LIN     = 77, OP_LIN_M   = 78,    // Logical invert
        OP_P_LIN_M = 79,
        OP_LES     = 80, OP_S_LES   = 81,
        OP_GRE     = 84, OP_S_GRE   = 85,
        OP_EQU     = 88, OP_S_EQU   = 89,
        OP_SHL     = 90, OP_S_SHL   = 91,
        OP_SHR     = 92, OP_S_SHR   = 93,
        OP_SRS     = 94, OP_S_SRS   = 95     // Arithmetic shift right
    } opcodeT;

    // --------------------------------------------------
    // Decoded fields
    // --------------------------------------------------

    // Where the ALU takes its operand from
    typedef enum logic [1:0] {
        SRC_NONE  = 2'd0,                    // No ALU operand, load or control only
        SRC_ACC   = 2'd1,                    // Plain unary forms
        SRC_MEM   = 2'd2,                    // Plain binary forms, _M and P_..._M forms
        SRC_STACK = 2'd3                     // S_ forms, stack top
    } operandSrcT;

endpackage

`default_nettype wire

// ==== common/aluPkg.sv ====
`default_nettype none

`include "instrDec_config.svh"

package aluPkg;

    // Base ALU function, before the acc/mem variant is chosen
    typedef enum logic [4:0] {
        FN_NONE, FN_LOAD,
        FN_ADD,  FN_MUL,  FN_DIV,  FN_MOD,  FN_SGN,
        FN_NEG,  FN_ABS,  FN_PST,                    // Unary arithmetic
        FN_AND,  FN_ORR,  FN_XOR,  FN_INV,           // Bitwise, INV unary
        FN_LAN,  FN_LOR,  FN_LIN,                    // Logical, LIN unary
        FN_LES,  FN_GRE,  FN_EQU,
        FN_SHL,  FN_SHR,  FN_SRS
    } aluFuncT;

    // --------------------------------------------------
    // ALU operation codes driven to the datapath
    // --------------------------------------------------

    // Unary functions have the mem variant at acc code plus one
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        ALU_NOP     = 0,                     // Also used by stores and I/O
        ALU_LOAD    = 1,
        ALU_ADD     = 2,
        ALU_MUL     = 4,
        ALU_DIV     = 6,
        ALU_MOD     = 8,
        ALU_SGN     = 9,
        ALU_NEG_ACC = 11, ALU_NEG_MEM = 12,
        ALU_ABS_ACC = 15, ALU_ABS_MEM = 16,
        ALU_PST_ACC = 19, ALU_PST_MEM = 20,
        ALU_AND     = 29,                    // 24 to 28 belong to float ops
        ALU_ORR     = 30,
        ALU_XOR     = 31,
        ALU_INV_ACC = 32, ALU_INV_MEM = 33,
        ALU_LAN     = 34,
        ALU_LOR     = 35,
        ALU_LIN_ACC = 36, ALU_LIN_MEM = 37,
        ALU_LES     = 38,
        ALU_GRE     = 40,
        ALU_EQU     = 42,
        ALU_SHL     = 43,
        ALU_SHR     = 44,
        ALU_SRS     = 45
    } aluOpT;

endpackage

`default_nettype wire

// ==== decode/opcodeClassifier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "instrDec_config.svh"

module opcodeClassifier (
    input  isaPkg::opcodeT     opcode,
    output aluPkg::aluFuncT    aluFunc,
    output isaPkg::operandSrcT operandSrc,
    output logic               push,
    output logic               pop,
    output logic               memWr,
    output logic               reqIn,
    output logic               outEn,
    output logic               ldi,
    output logic               sti,
    output logic               fft
);
    import isaPkg::*;
    import aluPkg::*;

    logic pushCtrl;      // Push from memory/stack/IO opcodes
    logic popCtrl;       // Pop from memory/stack opcodes
    logic stackForm;     // S_ form
    logic pushFirst;     // P_..._M form
    logic memForm;       // Unary on a memory word
    logic binaryFunc;    // Two-operand function
    logic unaryFunc;     // One-operand function

    // --------------------------------------------------
    // Opcode to base function and control strobes
    // --------------------------------------------------

    always_comb begin
        aluFunc  = FN_NONE;                  // Unlisted or disabled decodes as NOP
        pushCtrl = 1'b0;
        popCtrl  = 1'b0;
        memWr    = 1'b0;
        reqIn    = 1'b0;
        outEn    = 1'b0;
        ldi      = 1'b0;
        sti      = 1'b0;
        fft      = 1'b0;
        case (opcode)
            OP_LOD: if (`EN_MEM) aluFunc = FN_LOAD;
            OP_P_LOD: if (`EN_MEM) begin
                aluFunc  = FN_LOAD;
                pushCtrl = 1'b1;             // Save acc before loading
            end
            OP_LDI, OP_ILI: if (`EN_MEM) begin
                aluFunc = FN_LOAD;
                ldi     = 1'b1;
                fft     = (opcode == OP_ILI); // Bit-reversed address for FFT
            end
            OP_SET: if (`EN_MEM) memWr = 1'b1;
            OP_SET_P: if (`EN_MEM) begin
                aluFunc = FN_LOAD;           // Acc refilled from stack top
                memWr   = 1'b1;
                popCtrl = 1'b1;
            end
            OP_STI, OP_ISI: if (`EN_MEM) begin
                memWr   = 1'b1;
                sti     = 1'b1;
                fft     = (opcode == OP_ISI);
                popCtrl = 1'b1;              // Stack top carries the address
            end
            OP_PSH: if (`EN_STACK) pushCtrl = 1'b1;
            OP_POP: if (`EN_STACK) begin
                aluFunc = FN_LOAD;
                popCtrl = 1'b1;
            end
            OP_INN: if (`EN_IO) reqIn = 1'b1;
            OP_P_INN: if (`EN_IO) begin
                reqIn    = 1'b1;
                pushCtrl = 1'b1;
            end
            OP_OUT: if (`EN_IO) outEn = 1'b1;

            // Integer arithmetic, plain and S_ or _M forms share the function
            OP_ADD, OP_S_ADD: if (`EN_INT_ARITH) aluFunc = FN_ADD;
            OP_MLT, OP_S_MLT: if (`EN_INT_ARITH) aluFunc = FN_MUL;
            OP_DIV, OP_S_DIV: if (`EN_INT_ARITH) aluFunc = FN_DIV;
            OP_MOD, OP_S_MOD: if (`EN_INT_ARITH) aluFunc = FN_MOD;
            OP_SGN, OP_S_SGN: if (`EN_INT_ARITH) aluFunc = FN_SGN;
            OP_NEG, OP_NEG_M, OP_P_NEG_M: if (`EN_INT_ARITH) aluFunc = FN_NEG;
            OP_ABS, OP_ABS_M, OP_P_ABS_M: if (`EN_INT_ARITH) aluFunc = FN_ABS;
            OP_PST, OP_PST_M, OP_P_PST_M: if (`EN_INT_ARITH) aluFunc = FN_PST;

            // Bitwise and logical
            OP_AND, OP_S_AND: if (`EN_LOGIC) aluFunc = FN_AND;
            OP_ORR, OP_S_ORR: if (`EN_LOGIC) aluFunc = FN_ORR;
            OP_XOR, OP_S_XOR: if (`EN_LOGIC) aluFunc = FN_XOR;
            OP_INV, OP_INV_M, OP_P_INV_M: if (`EN_LOGIC) aluFunc = FN_INV;
            OP_LAN, OP_S_LAN: if (`EN_LOGIC) aluFunc = FN_LAN;
            OP_LOR, OP_S_LOR: if (`EN_LOGIC) aluFunc = FN_LOR;
            OP_LIN, OP_LIN_M, OP_P_LIN_M: if (`EN_LOGIC) aluFunc = FN_LIN;

            // Compare and shift
            OP_LES, OP_S_LES: if (`EN_COMPARE) aluFunc = FN_LES;
            OP_GRE, OP_S_GRE: if (`EN_COMPARE) aluFunc = FN_GRE;
            OP_EQU, OP_S_EQU: if (`EN_COMPARE) aluFunc = FN_EQU;
            OP_SHL, OP_S_SHL: if (`EN_SHIFT) aluFunc = FN_SHL;
            OP_SHR, OP_S_SHR: if (`EN_SHIFT) aluFunc = FN_SHR;
            OP_SRS, OP_S_SRS: if (`EN_SHIFT) aluFunc = FN_SRS;
            default: ;                       // Jumps, NOP and float opcodes
        endcase
    end

    // --------------------------------------------------
    // Operand form and stack traffic of ALU opcodes
    // --------------------------------------------------

    assign stackForm = opcode inside {OP_S_ADD, OP_S_MLT, OP_S_DIV, OP_S_MOD, OP_S_SGN,
                                      OP_S_AND, OP_S_ORR, OP_S_XOR, OP_S_LAN, OP_S_LOR,
                                      OP_S_LES, OP_S_GRE, OP_S_EQU, OP_S_SHL, OP_S_SHR,
                                      OP_S_SRS};
    assign pushFirst = opcode inside {OP_P_NEG_M, OP_P_ABS_M, OP_P_PST_M, OP_P_INV_M,
                                      OP_P_LIN_M};
    assign memForm   = pushFirst
                    || (opcode inside {OP_NEG_M, OP_ABS_M, OP_PST_M, OP_INV_M, OP_LIN_M});

    assign binaryFunc = aluFunc inside {FN_ADD, FN_MUL, FN_DIV, FN_MOD, FN_SGN, FN_AND,
                                        FN_ORR, FN_XOR, FN_LAN, FN_LOR, FN_LES, FN_GRE,
                                        FN_EQU, FN_SHL, FN_SHR, FN_SRS};
    assign unaryFunc  = aluFunc inside {FN_NEG, FN_ABS, FN_PST, FN_INV, FN_LIN};

    assign push = pushCtrl || (unaryFunc && pushFirst);  // Gated by the family enable
    assign pop  = popCtrl || (binaryFunc && stackForm);  // S_ form consumes stack top

    always_comb begin
        if (binaryFunc)
            operandSrc = stackForm ? SRC_STACK : SRC_MEM;
        else if (unaryFunc)
            operandSrc = memForm ? SRC_MEM : SRC_ACC;
        else
            operandSrc = SRC_NONE;           // Load, store, stack and I/O
    end

    // Strobe consistency seen by the stack and memory controllers
    always_comb begin
        assert (!(push && pop))
            else $error("push and pop both high for opcode %0d", opcode);
        assert (!(ldi && sti))
            else $error("ldi and sti both high for opcode %0d", opcode);
        assert (!fft || ldi || sti)
            else $error("fft without indirect access for opcode %0d", opcode);
    end

endmodule

`default_nettype wire

// ==== decode/aluOpEncoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "instrDec_config.svh"

module aluOpEncoder (
    input  logic               clk,
    input  logic               rstN,
    input  aluPkg::aluFuncT    aluFunc,
    input  isaPkg::operandSrcT operandSrc,
    output aluPkg::aluOpT      ulaOp
);
    import aluPkg::*;
    import isaPkg::*;

    logic [`ALU_OP_WIDTH-1:0] baseCode;     // Acc code for unary functions
    logic                     unaryOp;
    logic                     memVariant;   // Unary working on memory
    aluOpT                    nextOp;

    // --------------------------------------------------
    // Base function lookup
    // --------------------------------------------------

    always_comb begin
        unaryOp = 1'b0;
        case (aluFunc)
            FN_LOAD: baseCode = ALU_LOAD;
            FN_ADD:  baseCode = ALU_ADD;
            FN_MUL:  baseCode = ALU_MUL;
            FN_DIV:  baseCode = ALU_DIV;
            FN_MOD:  baseCode = ALU_MOD;
            FN_SGN:  baseCode = ALU_SGN;
            FN_AND:  baseCode = ALU_AND;
            FN_ORR:  baseCode = ALU_ORR;
            FN_XOR:  baseCode = ALU_XOR;
            FN_LAN:  baseCode = ALU_LAN;
            FN_LOR:  baseCode = ALU_LOR;
            FN_LES:  baseCode = ALU_LES;
            FN_GRE:  baseCode = ALU_GRE;
            FN_EQU:  baseCode = ALU_EQU;
            FN_SHL:  baseCode = ALU_SHL;
            FN_SHR:  baseCode = ALU_SHR;
            FN_SRS:  baseCode = ALU_SRS;
            FN_NEG, FN_ABS, FN_PST, FN_INV, FN_LIN: begin
                unaryOp = 1'b1;
                case (aluFunc)
                    FN_NEG:  baseCode = ALU_NEG_ACC;
                    FN_ABS:  baseCode = ALU_ABS_ACC;
                    FN_PST:  baseCode = ALU_PST_ACC;
                    FN_INV:  baseCode = ALU_INV_ACC;
                    default: baseCode = ALU_LIN_ACC;
                endcase
            end
            default: baseCode = ALU_NOP;    // FN_NONE
        endcase
    end

    // Binary functions ignore the source, the datapath muxes it
    assign memVariant = unaryOp && (operandSrc == SRC_MEM);
    assign nextOp     = aluOpT'(baseCode + `ALU_OP_WIDTH'(memVariant));

    // --------------------------------------------------
    // Output register, one cycle after the opcode
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rstN)
            ulaOp <= ALU_NOP;
        else
            ulaOp <= nextOp;
    end

    // ALU sees a NOP right after reset
    assert property (@(posedge clk) !rstN |=> ulaOp == ALU_NOP)
        else $error("ulaOp not cleared by reset");

    // No float or unused code ever reaches the ALU
    assert property (@(posedge clk) disable iff (!rstN)
        ulaOp inside {ALU_NOP, ALU_LOAD, ALU_ADD, ALU_MUL, ALU_DIV, ALU_MOD, ALU_SGN,
                      ALU_NEG_ACC, ALU_NEG_MEM, ALU_ABS_ACC, ALU_ABS_MEM, ALU_PST_ACC,
                      ALU_PST_MEM, ALU_AND, ALU_ORR, ALU_XOR, ALU_INV_ACC, ALU_INV_MEM,
                      ALU_LAN, ALU_LOR, ALU_LIN_ACC, ALU_LIN_MEM, ALU_LES, ALU_GRE,
                      ALU_EQU, ALU_SHL, ALU_SHR, ALU_SRS})
        else $error("ulaOp %0d outside the integer code set", ulaOp);

endmodule

`default_nettype wire

// ==== source/instrDec.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDec (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::opcodeT opcode,
    output logic           push,      // Data stack push
    output logic           pop,       // Data stack pop
    output logic           memWr,     // Data memory write
    output logic           reqIn,     // Input port request
    output logic           outEn,     // Output port enable
    output logic           ldi,       // Indirect load
    output logic           sti,       // Indirect store
    output logic           fft,       // Bit-reversed indirect address
    output aluPkg::aluOpT  ulaOp      // Registered ALU operation
);
    import isaPkg::*;
    import aluPkg::*;

    aluFuncT    aluFunc;              // Classifier to encoder
    operandSrcT operandSrc;

    // Strobes leave combinationally, the ALU code goes through the encoder
    opcodeClassifier classifier (
        .opcode     (opcode),
        .aluFunc    (aluFunc),
        .operandSrc (operandSrc),
        .push       (push),
        .pop        (pop),
        .memWr      (memWr),
        .reqIn      (reqIn),
        .outEn      (outEn),
        .ldi        (ldi),
        .sti        (sti),
        .fft        (fft)
    );

    aluOpEncoder encoder (
        .clk        (clk),
        .rstN       (rstN),
        .aluFunc    (aluFunc),
        .operandSrc (operandSrc),
        .ulaOp      (ulaOp)
    );

endmodule

`default_nettype wire

// ==== verif/instrDecTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecTb;
    import isaPkg::*;
    import aluPkg::*;

    localparam int    CLK_HALF     = 4;       // 8 ns period
    localparam int    DRIVE_DELAY  = 1;       // Inputs change after the rising edge
    localparam int    SAMPLE_DELAY = 2;       // Strobes settled well before the next edge
    localparam int    EDGE_TIMEOUT = 50;      // Bound on any single edge wait
    localparam int    NOP_OPCODE   = 96;
    localparam string TEST_FILE    = "verif/instrDecTests.txt";

    logic   clk;
    logic   rstN;
    opcodeT opcode;
    logic   push;
    logic   pop;
    logic   memWr;
    logic   reqIn;
    logic   outEn;
    logic   ldi;
    logic   sti;
    logic   fft;
    aluOpT  ulaOp;

    int         opList[$];                    // Opcode per test line
    logic [7:0] expStrobes[$];                // push pop memWr reqIn outEn ldi sti fft
    int         expCodes[$];                  // ulaOp one cycle later
    int         order[$];                     // Replay order of the current pass

    instrDec DUT (
        .clk   (clk),
        .rstN  (rstN),
        .opcode(opcode),
        .push  (push),
        .pop   (pop),
        .memWr (memWr),
        .reqIn (reqIn),
        .outEn (outEn),
        .ldi   (ldi),
        .sti   (sti),
        .fft   (fft),
        .ulaOp (ulaOp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // --------------------------------------------------
    // Failure reporting and bounded waits
    // --------------------------------------------------

    task automatic stopOnFailure();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic waitEdges(input int count);
        int  n;
        bit  seen;
        for (n = 0; n < count; n++) begin
            seen = 1'b0;
            fork
                begin
                    @(posedge clk);
                    seen = 1'b1;
                end
                #(EDGE_TIMEOUT);
            join_any
            disable fork;
            if (!seen) begin
                $display("Timeout: no rising clock edge within %0d ns", EDGE_TIMEOUT);
                stopOnFailure();
            end
        end
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    task automatic checkStrobes(input int op, input logic [7:0] expected);
        logic [7:0] seen;
        seen = {push, pop, memWr, reqIn, outEn, ldi, sti, fft};
        assert (seen === expected) else begin
            $display("[FAIL] %0t ns: opcode %0d strobes %b, expected %b",
                     $time, op, seen, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkAluCode(input int op, input int expected);
        logic [31:0] seen;
        seen = 32'(ulaOp);                    // Unknown bits stay unknown
        assert (seen === expected) else begin
            $display("[FAIL] %0t ns: opcode %0d ulaOp %0d, expected %0d",
                     $time, op, ulaOp, expected);
            stopOnFailure();
        end
    endtask

    task automatic loadTests();
        int    fd;
        int    op;
        int    code;
        logic  [7:0] strb;
        string line;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test file %s", TEST_FILE);
            stopOnFailure();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%d %b %d", op, strb, code) == 3) begin  // Skips # lines
                opList.push_back(op);
                expStrobes.push_back(strb);
                expCodes.push_back(code);
            end
        end
        $fclose(fd);
        if (opList.size() == 0) begin
            $display("The test file %s holds no test lines", TEST_FILE);
            stopOnFailure();
        end
    endtask

    // One opcode per cycle with the previous opcode's ulaOp checked at the same step
    task automatic runPass();
        int k;
        int idx;
        for (k = 0; k < order.size(); k++) begin
            waitEdges(1);
            #(DRIVE_DELAY);
            if (k > 0)
                checkAluCode(opList[order[k-1]], expCodes[order[k-1]]);
            idx    = order[k];
            opcode = opcodeT'(opList[idx]);
            #(SAMPLE_DELAY);
            checkStrobes(opList[idx], expStrobes[idx]);
        end
        waitEdges(1);
        #(DRIVE_DELAY);
        checkAluCode(opList[order[order.size()-1]], expCodes[order[order.size()-1]]);
        opcode = opcodeT'(NOP_OPCODE);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        int i;
        int j;
        int tmp;
        rstN   = 1'b0;
        opcode = opcodeT'(NOP_OPCODE);
        void'($urandom(34));                  // Seeds the shuffle
        loadTests();

        waitEdges(3);                         // Reset held for 3 cycles
        #(DRIVE_DELAY);
        rstN = 1'b1;
        #(SAMPLE_DELAY);
        checkAluCode(NOP_OPCODE, 0);          // Register cleared by reset
        checkStrobes(NOP_OPCODE, 8'b0);

        for (i = 0; i < opList.size(); i++)
            order.push_back(i);
        runPass();                            // File order

        for (i = order.size() - 1; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        runPass();                            // Shuffled order back to back

        $display("Checked %0d opcodes in file order and shuffled order", opList.size());
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/instrDecTests.txt ====
# opcode  strobes  ulaOp   (decimal, binary, decimal)
# strobe bits left to right: push pop memWr reqIn outEn ldi sti fft
0   00000000  1
1   10000000  1
2   00000100  1
3   00000101  1
4   00100000  0
5   01100000  1
6   01100010  0
7   01100011  0
8   10000000  0
9   01000000  1
10  00010000  0
12  10010000  0
14  00001000  0
19  00000000  2
20  01000000  2
27  00000000  6
28  01000000  6
64  00000000  29
65  01000000  29
73  00000000  34
74  01000000  34
80  00000000  38
81  01000000  38
90  00000000  43
91  01000000  43
37  00000000  11
38  00000000  12
39  10000000  12
70  00000000  32
71  00000000  33
72  10000000  33
77  00000000  36
78  00000000  37
79  10000000  37
15  00000000  0
18  00000000  0
21  00000000  0
96  00000000  0
127 00000000  0

// ==== instrDec.f ====
+incdir+common
common/isaPkg.sv
common/aluPkg.sv
decode/opcodeClassifier.sv
decode/aluOpEncoder.sv
source/instrDec.sv
verif/instrDecTb.sv

// ==== Bender.yml ====
package:
  name: instrDec

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/aluPkg.sv
      - decode/opcodeClassifier.sv
      - decode/aluOpEncoder.sv
      - source/instrDec.sv
  - target: test
    files:
      - verif/instrDecTb.sv
